// File: logic/fetch_pkg.sv
package fetch_pkg;

  // PC field widths.
  localparam int offset_bits = 4;
  localparam int index_bits = 2;
  localparam int tag_bits = 32 - offset_bits - index_bits;

  localparam int line_count = 1 << index_bits;
  localparam int beats_per_line = 4;

  localparam logic [31:0] reset_pc = 32'h8000_0000;

  typedef struct packed {
    logic [tag_bits-1:0]   tag;
    logic [index_bits-1:0] index;
    logic [1:0]            word_sel;
    logic [1:0]            byte_off;
  } pc_fields_t;

  // Flat view for fill shifting, word view for hit selection.
  typedef union packed {
    logic [beats_per_line*32-1:0]         flat;
    logic [beats_per_line-1:0][31:0]      words;
  } cache_line_t;

  typedef struct packed {
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic        arvalid;
  } axi_ar_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rlast;
  } axi_r_t;

  // Configuration register offsets.
  typedef enum logic [1:0] {
    ctrl   = 2'd0,
    hits   = 2'd1,
    misses = 2'd2
  } cfg_addr_t;

endpackage

// File: logic/icache_array.sv
`timescale 1ns/1ps

module icache_array (
  input  logic                               clock,
  input  logic                               reset,
  input  fetch_pkg::pc_fields_t              lookup_pc,
  output logic                               hit,
  output logic [31:0]                        hit_word,
  input  logic [fetch_pkg::index_bits-1:0]   fill_index,
  input  logic [fetch_pkg::tag_bits-1:0]     fill_tag,
  input  logic                               fill_valid,
  input  logic [31:0]                        fill_data,
  input  logic                               fill_last,
  input  logic                               flush
);

  fetch_pkg::cache_line_t            lines [fetch_pkg::line_count];
  logic [fetch_pkg::tag_bits-1:0]    tags [fetch_pkg::line_count];
  logic [fetch_pkg::line_count-1:0]  valid;
  logic                              filling;
  fetch_pkg::cache_line_t            lookup_line;

  assign lookup_line = lines[lookup_pc.index];
  assign hit = valid[lookup_pc.index] && (tags[lookup_pc.index] == lookup_pc.tag);
  assign hit_word = lookup_line.words[lookup_pc.word_sel];

  // Beats enter at the top, so the first beat ends up in word 0.
  always_ff @(posedge clock) begin
    if (fill_valid) begin
      lines[fill_index].flat <= {fill_data, lines[fill_index].flat[127:32]};
      if (fill_last) begin
        tags[fill_index] <= fill_tag;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
      filling <= 1'b0;
    end else begin
      if (fill_valid) begin
        filling <= !fill_last;
      end
      if (flush) begin
        valid <= '0;
      end else if (fill_valid && fill_last) begin
        valid[fill_index] <= 1'b1;
      end else if (fill_valid && !filling) begin
        // Line is stale while its beats are being replaced.
        valid[fill_index] <= 1'b0;
      end
    end
  end

  // A line only turns valid on a last beat that no flush cancelled.
  flush_wins: assert property (
    @(posedge clock) disable iff (reset)
    ((valid & ~$past(valid)) != '0) |-> $past(fill_valid && fill_last && !flush)
  );

endmodule

// File: logic/refill_master.sv
`timescale 1ns/1ps

module refill_master (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               refill_start,
  input  logic [31:0]                        refill_addr,
  output fetch_pkg::axi_ar_t                 ar,
  input  logic                               arready,
  output logic                               rready,
  input  fetch_pkg::axi_r_t                  r,
  output logic [fetch_pkg::index_bits-1:0]   fill_index,
  output logic [fetch_pkg::tag_bits-1:0]     fill_tag,
  output logic                               fill_valid,
  output logic [31:0]                        fill_data,
  output logic                               fill_last,
  output logic                               fill_done
);

  logic [31:fetch_pkg::offset_bits]                  line_addr;
  logic                                              arvalid;
  logic [$clog2(fetch_pkg::beats_per_line)-1:0]      beat_count;

  assign ar.araddr = {line_addr, {fetch_pkg::offset_bits{1'b0}}};
  assign ar.arlen = 8'(fetch_pkg::beats_per_line - 1);
  assign ar.arvalid = arvalid;

  assign fill_valid = rready && r.rvalid;
  assign fill_data = r.rdata;
  assign fill_last = r.rlast;
  assign fill_index = line_addr[fetch_pkg::offset_bits +: fetch_pkg::index_bits];
  assign fill_tag = line_addr[31 -: fetch_pkg::tag_bits];

  always_ff @(posedge clock) begin
    if (refill_start) begin
      line_addr <= refill_addr[31:fetch_pkg::offset_bits];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      arvalid <= 1'b0;
      rready <= 1'b0;
      fill_done <= 1'b0;
      beat_count <= '0;
    end else begin
      fill_done <= fill_valid && r.rlast;
      if (refill_start) begin
        arvalid <= 1'b1;
        beat_count <= '0;
      end else if (arvalid && arready) begin
        arvalid <= 1'b0;
        rready <= 1'b1;
      end
      if (fill_valid) begin
        beat_count <= beat_count + 1'b1;
        if (r.rlast) begin
          rready <= 1'b0;
        end
      end
    end
  end

  // Burst length must match the line size.
  rlast_on_last_beat: assert property (
    @(posedge clock) disable iff (reset)
    fill_valid |-> (r.rlast == (beat_count == 2'(fetch_pkg::beats_per_line - 1)))
  );

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   redirect,
  input  logic [31:0]            redirect_pc,
  input  logic                   idu_ready,
  output logic                   inst_valid,
  output logic [31:0]            inst,
  output logic [31:0]            inst_pc,
  output logic                   inst_addr_misaligned,
  output fetch_pkg::pc_fields_t  lookup_pc,
  input  logic                   hit,
  input  logic [31:0]            hit_word,
  output logic                   refill_start,
  output logic [31:0]            refill_addr,
  input  logic                   fill_done,
  input  logic                   cache_enable,
  output logic                   hit_event,
  output logic                   miss_event
);

  typedef enum logic [1:0] {
    st_lookup,
    st_refill,
    st_fault
  } state_t;

  state_t       state;
  logic [31:0]  pc;
  logic         take_fill;
  logic         slot_free;
  logic         use_hit;

  assign lookup_pc = pc;
  assign slot_free = !inst_valid || idu_ready;
  // With the cache off, only the word just refilled may be taken.
  assign use_hit = hit && (cache_enable || take_fill);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_lookup;
      pc <= fetch_pkg::reset_pc;
      take_fill <= 1'b0;
      inst_valid <= 1'b0;
      inst_addr_misaligned <= 1'b0;
      refill_start <= 1'b0;
      hit_event <= 1'b0;
      miss_event <= 1'b0;
    end else begin
      refill_start <= 1'b0;
      hit_event <= 1'b0;
      miss_event <= 1'b0;
      inst_addr_misaligned <= 1'b0;
      if (inst_valid && idu_ready) begin
        inst_valid <= 1'b0;
      end

      if (redirect) begin
        pc <= redirect_pc;
        inst_valid <= 1'b0;
        if (state == st_fault) begin
          state <= st_lookup;
        end
      end else if (state == st_lookup && slot_free) begin
        take_fill <= 1'b0;
        if (pc[1:0] != 2'b00) begin
          inst_pc <= pc;
          inst_addr_misaligned <= 1'b1;
          state <= st_fault;
        end else if (use_hit) begin
          inst <= hit_word;
          inst_pc <= pc;
          inst_valid <= 1'b1;
          pc <= pc + 32'd4;
          hit_event <= !take_fill;
        end else begin
          refill_addr <= {pc[31:fetch_pkg::offset_bits], {fetch_pkg::offset_bits{1'b0}}};
          refill_start <= 1'b1;
          miss_event <= 1'b1;
          state <= st_refill;
        end
      end

      // An in-flight refill always finishes, even across a redirect.
      if (state == st_refill && fill_done) begin
        state <= st_lookup;
        take_fill <= !cache_enable;
      end
    end
  end

  // No new refill request inside a refill wait.
  single_refill: assert property (
    @(posedge clock) disable iff (reset)
    (state == st_refill && $past(state) == st_refill) |-> !refill_start
  );

endmodule

// File: logic/fetch_ctrl_regs.sv
`timescale 1ns/1ps

module fetch_ctrl_regs (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  cfg_write,
  input  fetch_pkg::cfg_addr_t  cfg_addr,
  input  logic [31:0]           cfg_wdata,
  output logic [31:0]           cfg_rdata,
  output logic                  cache_enable,
  output logic                  flush,
  input  logic                  hit_event,
  input  logic                  miss_event
);

  logic [31:0] hit_count;
  logic [31:0] miss_count;

  always_ff @(posedge clock) begin
    if (reset) begin
      cache_enable <= 1'b1;
      flush <= 1'b0;
      hit_count <= '0;
      miss_count <= '0;
    end else begin
      flush <= 1'b0;
      if (cfg_write && cfg_addr == fetch_pkg::ctrl) begin
        cache_enable <= cfg_wdata[0];
        flush <= cfg_wdata[1];
      end

      // A write to a counter clears it.
      if (cfg_write && cfg_addr == fetch_pkg::hits) begin
        hit_count <= '0;
      end else if (hit_event) begin
        hit_count <= hit_count + 32'd1;
      end

      if (cfg_write && cfg_addr == fetch_pkg::misses) begin
        miss_count <= '0;
      end else if (miss_event) begin
        miss_count <= miss_count + 32'd1;
      end
    end
  end

  always_comb begin
    case (cfg_addr)
      // Flush bit is write-only.
      fetch_pkg::ctrl:   cfg_rdata = {31'd0, cache_enable};
      fetch_pkg::hits:   cfg_rdata = hit_count;
      fetch_pkg::misses: cfg_rdata = miss_count;
      default:           cfg_rdata = '0;
    endcase
  end

endmodule

// File: logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  redirect,
  input  logic [31:0]           redirect_pc,
  input  logic                  idu_ready,
  output logic                  inst_valid,
  output logic [31:0]           inst,
  output logic [31:0]           inst_pc,
  output logic                  inst_addr_misaligned,
  output fetch_pkg::axi_ar_t    ar,
  input  logic                  arready,
  output logic                  rready,
  input  fetch_pkg::axi_r_t     r,
  input  logic                  cfg_write,
  input  fetch_pkg::cfg_addr_t  cfg_addr,
  input  logic [31:0]           cfg_wdata,
  output logic [31:0]           cfg_rdata
);

  fetch_pkg::pc_fields_t               lookup_pc;
  logic                                hit;
  logic [31:0]                         hit_word;
  logic                                refill_start;
  logic [31:0]                         refill_addr;
  logic [fetch_pkg::index_bits-1:0]    fill_index;
  logic [fetch_pkg::tag_bits-1:0]      fill_tag;
  logic                                fill_valid;
  logic [31:0]                         fill_data;
  logic                                fill_last;
  logic                                fill_done;
  logic                                cache_enable;
  logic                                flush;
  logic                                hit_event;
  logic                                miss_event;

  fetch_unit u_fetch_unit (.*);

  icache_array u_icache_array (.*);

  refill_master u_refill_master (.*);

  fetch_ctrl_regs u_fetch_ctrl_regs (.*);

endmodule

// File: test/mem_model.sv
`timescale 1ns/1ps

module mem_model (
  input  logic               clock,
  input  logic               reset,
  input  fetch_pkg::axi_ar_t ar,
  output logic               arready,
  input  logic               rready,
  output fetch_pkg::axi_r_t  r
);

  logic        busy;
  logic [31:0] addr;
  logic [7:0]  beats_left;
  logic [1:0]  delay;
  logic        rvalid_q;

  // Read data is derived from the beat address.
  assign r.rdata = addr ^ 32'h5a5a_0000;
  assign r.rresp = 2'b00;
  assign r.rvalid = rvalid_q;
  assign r.rlast = (beats_left == 8'd0);

  always @(posedge clock) begin
    if (reset) begin
      arready <= 1'b0;
      busy <= 1'b0;
      addr <= '0;
      beats_left <= '0;
      delay <= '0;
      rvalid_q <= 1'b0;
    end else begin
      arready <= 1'b0;
      if (!busy) begin
        if (ar.arvalid && arready) begin
          busy <= 1'b1;
          addr <= ar.araddr;
          beats_left <= ar.arlen;
          delay <= 2'($urandom_range(3, 0));
        end else if (ar.arvalid) begin
          if (delay == 2'd0) begin
            arready <= 1'b1;
          end else begin
            delay <= delay - 2'd1;
          end
        end
      end else if (rvalid_q && rready) begin
        rvalid_q <= 1'b0;
        addr <= addr + 32'd4;
        delay <= 2'($urandom_range(3, 0));
        if (beats_left == 8'd0) begin
          busy <= 1'b0;
        end else begin
          beats_left <= beats_left - 8'd1;
        end
      end else if (!rvalid_q) begin
        if (delay == 2'd0) begin
          rvalid_q <= 1'b1;
        end else begin
          delay <= delay - 2'd1;
        end
      end
    end
  end

endmodule

// File: test/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

  localparam int test_count = 6;
  localparam logic [31:0] park_pc = 32'h8000_0302;

  logic                 clock;
  logic                 reset;
  logic                 redirect;
  logic [31:0]          redirect_pc;
  logic                 idu_ready;
  logic                 inst_valid;
  logic [31:0]          inst;
  logic [31:0]          inst_pc;
  logic                 inst_addr_misaligned;
  fetch_pkg::axi_ar_t   ar;
  logic                 arready;
  logic                 rready;
  fetch_pkg::axi_r_t    r;
  logic                 cfg_write;
  fetch_pkg::cfg_addr_t cfg_addr;
  logic [31:0]          cfg_wdata;
  logic [31:0]          cfg_rdata;

  int errors;
  int tests_run;
  int tests_failed;
  int test_start_errors;
  int ar_count;
  int misaligned_count;
  int valid_count;
  logic [31:0] seen_pc [$];
  logic [31:0] seen_inst [$];

  fetch_top DUT (.*);

  mem_model memory (
    .clock(clock),
    .reset(reset),
    .ar(ar),
    .arready(arready),
    .rready(rready),
    .r(r)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial begin
    #(test_count * 2000 * 40);
    $display("watchdog expired before the tests finished");
    $display("Something failed");
    $finish;
  end

  // Collector and bus monitors.
  always @(posedge clock) begin
    if (!reset) begin
      if (inst_valid && idu_ready) begin
        seen_pc.push_back(inst_pc);
        seen_inst.push_back(inst);
      end
      if (ar.arvalid && arready) begin
        ar_count++;
        // One line per burst, four beats from a line boundary.
        check_value("arlen", 32'd3, 32'(ar.arlen));
        check_value("araddr_offset", 32'd0, 32'(ar.araddr[3:0]));
      end
      if (inst_addr_misaligned) misaligned_count++;
      if (inst_valid) valid_count++;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic write_cfg(input fetch_pkg::cfg_addr_t addr, input logic [31:0] data);
    cfg_write <= 1'b1;
    cfg_addr <= addr;
    cfg_wdata <= data;
    @(posedge clock);
    cfg_write <= 1'b0;
  endtask

  task automatic read_cfg(input fetch_pkg::cfg_addr_t addr, output logic [31:0] data);
    cfg_addr <= addr;
    @(posedge clock);
    data = cfg_rdata;
  endtask

  task automatic redirect_to(input logic [31:0] target);
    redirect <= 1'b1;
    redirect_pc <= target;
    @(posedge clock);
    redirect <= 1'b0;
  endtask

  // Waits for an instruction, holds it for a while, then consumes it.
  // The last one of a block parks fetch on a misaligned pc.
  task automatic take_one(input bit last, input int max_hold);
    int wait_cycles;
    int hold;
    logic [31:0] held_inst;
    logic [31:0] held_pc;
    wait_cycles = 0;
    @(posedge clock);
    while (!inst_valid && wait_cycles < 400) begin
      wait_cycles++;
      @(posedge clock);
    end
    if (!inst_valid) begin
      $display("timed out waiting for inst_valid at time %0t", $time);
      errors++;
      return;
    end
    held_inst = inst;
    held_pc = inst_pc;
    hold = (max_hold > 0) ? int'($urandom_range(max_hold, 0)) : 0;
    repeat (hold) begin
      @(posedge clock);
      assert (inst_valid) else begin
        $display("inst_valid dropped under back-pressure at time %0t", $time);
        errors++;
      end
      check_value("inst", held_inst, inst);
      check_value("inst_pc", held_pc, inst_pc);
    end
    idu_ready <= 1'b1;
    if (last) begin
      redirect <= 1'b1;
      redirect_pc <= park_pc;
    end
    @(posedge clock);
    idu_ready <= 1'b0;
    redirect <= 1'b0;
  endtask

  task automatic fetch_block(input logic [31:0] start, input int count, input int max_hold);
    int base;
    logic [31:0] expected_pc;
    base = seen_pc.size();
    for (int i = 0; i < count; i++) begin
      take_one(i == count - 1, max_hold);
    end
    @(posedge clock);
    check_value("consumed_count", 32'(base + count), 32'(seen_pc.size()));
    for (int i = 0; i < count && base + i < seen_pc.size(); i++) begin
      expected_pc = start + 32'(4 * i);
      check_value("inst_pc", expected_pc, seen_pc[base + i]);
      check_value("inst", expected_pc ^ 32'h5a5a_0000, seen_inst[base + i]);
    end
  endtask

  task automatic begin_test;
    test_start_errors = errors;
    tests_run++;
  endtask

  task automatic end_test(input string name);
    if (errors > test_start_errors) begin
      tests_failed++;
      $display("test %s: FAIL (%0d errors)", name, errors - test_start_errors);
    end else begin
      $display("test %s: PASS", name);
    end
  endtask

  task automatic cold_fetch_test;
    logic [31:0] misses;
    begin_test();
    // Idle outputs and an enabled cache straight out of reset.
    check_value("inst_valid", 32'd0, 32'(inst_valid));
    check_value("arvalid", 32'd0, 32'(ar.arvalid));
    check_value("rready", 32'd0, 32'(rready));
    check_value("inst_addr_misaligned", 32'd0, 32'(inst_addr_misaligned));
    check_value("ctrl", 32'd1, cfg_rdata);
    fetch_block(fetch_pkg::reset_pc, 8, 0);
    read_cfg(fetch_pkg::misses, misses);
    check_value("miss_count", 32'd2, misses);
    end_test("cold_fetch");
  endtask

  task automatic hit_test;
    logic [31:0] hits_before;
    logic [31:0] misses_before;
    logic [31:0] value;
    int ar_before;
    begin_test();
    read_cfg(fetch_pkg::hits, hits_before);
    read_cfg(fetch_pkg::misses, misses_before);
    ar_before = ar_count;
    redirect_to(fetch_pkg::reset_pc);
    fetch_block(fetch_pkg::reset_pc, 8, 0);
    check_value("ar_transfers", 32'(ar_before), 32'(ar_count));
    read_cfg(fetch_pkg::hits, value);
    check_value("hit_count", hits_before + 32'd8, value);
    read_cfg(fetch_pkg::misses, value);
    check_value("miss_count", misses_before, value);
    end_test("hits");
  endtask

  task automatic conflict_test;
    logic [31:0] misses_before;
    logic [31:0] value;
    begin_test();
    read_cfg(fetch_pkg::misses, misses_before);
    redirect_to(fetch_pkg::reset_pc + 32'd64);
    fetch_block(fetch_pkg::reset_pc + 32'd64, 4, 0);
    read_cfg(fetch_pkg::misses, value);
    check_value("miss_count", misses_before + 32'd1, value);
    redirect_to(fetch_pkg::reset_pc);
    fetch_block(fetch_pkg::reset_pc, 4, 0);
    read_cfg(fetch_pkg::misses, value);
    check_value("miss_count", misses_before + 32'd2, value);
    end_test("conflict");
  endtask

  task automatic misaligned_test;
    int ar_before;
    int mis_before;
    int valid_before;
    begin_test();
    // The pulse from the previous park is still on its way.
    repeat (4) @(posedge clock);
    ar_before = ar_count;
    mis_before = misaligned_count;
    valid_before = valid_count;
    redirect_to(fetch_pkg::reset_pc + 32'd2);
    repeat (20) @(posedge clock);
    check_value("inst_addr_misaligned_cycles", 32'd1, 32'(misaligned_count - mis_before));
    check_value("ar_transfers", 32'(ar_before), 32'(ar_count));
    check_value("inst_valid_cycles", 32'd0, 32'(valid_count - valid_before));
    end_test("misaligned");
  endtask

  task automatic config_test;
    logic [31:0] misses_before;
    logic [31:0] hits_before;
    logic [31:0] value;
    begin_test();
    // Flush with the cache left enabled.
    write_cfg(fetch_pkg::ctrl, 32'd3);
    read_cfg(fetch_pkg::ctrl, value);
    check_value("ctrl", 32'd1, value);
    read_cfg(fetch_pkg::misses, misses_before);
    redirect_to(fetch_pkg::reset_pc);
    fetch_block(fetch_pkg::reset_pc, 4, 0);
    read_cfg(fetch_pkg::misses, value);
    check_value("miss_count", misses_before + 32'd1, value);

    write_cfg(fetch_pkg::ctrl, 32'd0);
    read_cfg(fetch_pkg::misses, misses_before);
    read_cfg(fetch_pkg::hits, hits_before);
    redirect_to(fetch_pkg::reset_pc);
    fetch_block(fetch_pkg::reset_pc, 4, 0);
    read_cfg(fetch_pkg::misses, value);
    check_value("miss_count", misses_before + 32'd4, value);
    read_cfg(fetch_pkg::hits, value);
    check_value("hit_count", hits_before, value);
    write_cfg(fetch_pkg::ctrl, 32'd1);
    end_test("config");
  endtask

  task automatic backpressure_test;
    begin_test();
    redirect_to(fetch_pkg::reset_pc + 32'h100);
    fetch_block(fetch_pkg::reset_pc + 32'h100, 16, 4);
    end_test("backpressure");
  endtask

  initial begin
    void'($urandom(32'hb12b_5a8e));
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    test_start_errors = 0;
    ar_count = 0;
    misaligned_count = 0;
    valid_count = 0;
    reset = 1'b1;
    redirect = 1'b0;
    redirect_pc = '0;
    idu_ready = 1'b0;
    cfg_write = 1'b0;
    cfg_addr = fetch_pkg::ctrl;
    cfg_wdata = '0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;

    cold_fetch_test();
    hit_test();
    conflict_test();
    misaligned_test();
    config_test();
    backpressure_test();

    $display("tests run=%0d failed=%0d errors=%0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: src.f
logic/fetch_pkg.sv
logic/icache_array.sv
logic/refill_master.sv
logic/fetch_unit.sv
logic/fetch_ctrl_regs.sv
logic/fetch_top.sv
test/mem_model.sv
test/fetch_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the fetch stage simulation with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fetch_tb -f src.f -o fetch_sim
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
  exit 1
fi
if ! grep -q "Everything OK" sim.log; then
  exit 1
fi
exit 0
